//--- src/host_mem_pkg.sv
package host_mem_pkg;

    typedef enum logic [3:0] {
        WR_IDLE,
        WR_DATA_INIT,
        WR_CALC_DATA,
        WR_PREPARE_HEADER,
        WR_TRANSMIT_HEADER,
        WR_DEASSERT_HEADER,
        WR_GET_DATA_FIFO,
        WR_WAIT_DATA_FIFO,
        WR_PREPARE_DATA,
        WR_TRANSMIT_DATA,
        WR_DEASSERT_DATA,
        WR_COMPLETE,
        WR_CLEANUP
    } mem_write_state_t;

    typedef logic [127:0] tlp_beat_t;
    typedef logic [3:0]   dw_keep_t;
    typedef logic [3:0]   byte_en_t;
    typedef logic [63:0]  mem_addr_t;
    typedef logic [31:0]  mem_len_t;

    localparam mem_len_t    MAX_PAYLOAD_BYTES = 32'd128;   // 32 DW per TLP
    localparam logic [7:0]  FMT_TYPE_MWR64    = 8'h60;     // 4DW header, with data
    localparam int unsigned CLEANUP_CYCLES    = 8;

endpackage

//--- src/mem_write_arbiter.sv
`timescale 1ns/1ns

module mem_write_arbiter #(
    parameter int N_REQ = 3
) (
    input  logic                                         clk_pcie,
    input  logic                                         rst,
    input  host_mem_pkg::mem_addr_t [N_REQ-1:0]          req_address,
    input  host_mem_pkg::mem_len_t  [N_REQ-1:0]          req_length,
    input  logic                    [N_REQ-1:0]          req_has_data,
    input  host_mem_pkg::tlp_beat_t [N_REQ-1:0]          req_din,
    input  logic                    [N_REQ-1:0]          req_wr_en,
    input  logic                    [N_REQ-1:0]          req_wr_done,
    output host_mem_pkg::mem_write_state_t [N_REQ-1:0]   req_state,
    input  host_mem_pkg::mem_write_state_t               engine_state,
    output host_mem_pkg::mem_addr_t                      sel_address,
    output host_mem_pkg::mem_len_t                       sel_length,
    output logic                                         sel_has_data,
    output logic                                         sel_wr_done,
    output host_mem_pkg::tlp_beat_t                      fifo_din,
    output logic                                         fifo_wr_en
);
    import host_mem_pkg::*;

    localparam int IDX_W = (N_REQ > 1) ? $clog2(N_REQ) : 1;

    logic [IDX_W-1:0] sel_idx;
    logic             sel_valid;
    logic [IDX_W-1:0] new_idx;
    logic             new_valid;
    logic             keep_pick;

    // Fixed priority, lowest index wins
    always_comb begin
        new_idx   = '0;
        new_valid = 1'b0;
        for (int i = N_REQ - 1; i >= 0; i--) begin
            if (req_has_data[i]) begin
                new_idx   = IDX_W'(i);
                new_valid = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            sel_idx   <= '0;
            sel_valid <= 1'b0;
        end else if (engine_state == WR_IDLE) begin
            sel_idx   <= new_idx;
            sel_valid <= new_valid;
        end
    end

    // At idle the engine only starts once the pick is settled, so a
    // lower requester arriving late cannot swap the index under it
    assign keep_pick    = sel_valid && new_valid && (new_idx == sel_idx);
    assign sel_has_data = sel_valid && req_has_data[sel_idx]
                          && ((engine_state != WR_IDLE) || keep_pick);

    always_comb begin
        sel_address = '0;
        sel_length  = '0;
        sel_wr_done = 1'b0;
        fifo_din    = '0;
        fifo_wr_en  = 1'b0;
        if (sel_valid) begin
            sel_address = req_address[sel_idx];
            sel_length  = req_length[sel_idx];
            sel_wr_done = req_wr_done[sel_idx];
            fifo_din    = req_din[sel_idx];
            fifo_wr_en  = req_wr_en[sel_idx];
        end
        for (int i = 0; i < N_REQ; i++) begin
            req_state[i] = (sel_valid && sel_idx == IDX_W'(i)) ? engine_state : WR_IDLE;
        end
    end

    a_sel_frozen: assert property (@(posedge clk_pcie) disable iff (rst)
        (engine_state != WR_IDLE) |=> $stable(sel_idx) && sel_valid);

endmodule

//--- src/payload_fifo.sv
`timescale 1ns/1ns

module payload_fifo #(
    parameter int FIFO_DEPTH = 128
) (
    input  logic                    clk_pcie,
    input  logic                    rst,
    input  logic                    flush,
    input  logic                    wr_en,
    input  host_mem_pkg::tlp_beat_t din,
    input  logic                    rd_en,
    output host_mem_pkg::tlp_beat_t dout,
    output logic                    empty,
    output logic                    full
);
    import host_mem_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);   // Depth is a power of two

    tlp_beat_t     mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_wr;
    logic          do_rd;

    assign empty = (count == '0);
    assign full  = (count == (AW+1)'(FIFO_DEPTH));
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    always_ff @(posedge clk_pcie) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (AW+1)'(do_wr) - (AW+1)'(do_rd);
        end
    end

    // Storage and read register
    always_ff @(posedge clk_pcie) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
        if (do_rd) begin
            dout <= mem[rd_ptr];
        end
    end

    a_no_overrun: assert property (@(posedge clk_pcie) disable iff (rst || flush)
        !(wr_en && full) && !(rd_en && empty));

endmodule

//--- src/write_tlp_header.sv
`timescale 1ns/1ns

module write_tlp_header (
    input  host_mem_pkg::mem_len_t  chunk_bytes,
    input  logic                    more_after,
    input  host_mem_pkg::mem_addr_t address,
    input  logic [15:0]             pcie_id,
    output host_mem_pkg::tlp_beat_t header
);
    import host_mem_pkg::*;

    logic [9:0] dw_length;
    byte_en_t   tail_be;
    byte_en_t   first_be;
    byte_en_t   last_be;

    // Bytes used in the final dword, 0 means all four
    always_comb begin
        case (chunk_bytes[1:0])
            2'd1:    tail_be = 4'b0001;
            2'd2:    tail_be = 4'b0011;
            2'd3:    tail_be = 4'b0111;
            default: tail_be = 4'b1111;
        endcase
    end

    assign dw_length = chunk_bytes[11:2] + 10'(chunk_bytes[1:0] != 2'b00);

    assign first_be = (chunk_bytes >= 32'd4) ? 4'hF : tail_be;
    assign last_be  = more_after              ? 4'hF :
                      (chunk_bytes <= 32'd4)  ? 4'h0 : tail_be;   // Single DW has no last BE

    assign header = {
        address[31:0],
        address[63:32],
        pcie_id[7:0], pcie_id[15:8], 8'h00, last_be, first_be,
        FMT_TYPE_MWR64, 14'h0, dw_length
    };

endmodule

//--- src/write_tlp_engine.sv
`timescale 1ns/1ns

module write_tlp_engine (
    input  logic                             clk_pcie,
    input  logic                             rst,
    input  host_mem_pkg::mem_addr_t          sel_address,
    input  host_mem_pkg::mem_len_t           sel_length,
    input  logic                             sel_has_data,
    input  logic                             sel_wr_done,
    input  host_mem_pkg::tlp_beat_t          fifo_dout,
    input  logic                             tlp_ready,
    input  host_mem_pkg::tlp_beat_t          header,
    output host_mem_pkg::mem_len_t           chunk_bytes,
    output logic                             more_after,
    output host_mem_pkg::mem_addr_t          chunk_address,
    output host_mem_pkg::mem_write_state_t   engine_state,
    output logic                             fifo_rd_en,
    output logic                             fifo_flush,
    output host_mem_pkg::tlp_beat_t          tlp_data,
    output host_mem_pkg::dw_keep_t           tlp_keep_dw,
    output logic                             tlp_first,
    output logic                             tlp_last,
    output logic                             tlp_pending,
    output logic                             tlp_valid
);
    import host_mem_pkg::*;

    mem_write_state_t state;
    logic [3:0]       cleanup_cnt;
    mem_len_t         data_remaining;    // Bytes after the current chunk
    mem_len_t         chunk_remaining;   // Bytes left in the current chunk
    logic [2:0]       beat_dwords;
    mem_addr_t        write_address;

    // Host expects each dword byte-reversed
    function automatic tlp_beat_t swap_dwords(input tlp_beat_t beat);
        tlp_beat_t res;
        for (int d = 0; d < 4; d++) begin
            for (int b = 0; b < 4; b++) begin
                res[d*32 + b*8 +: 8] = beat[d*32 + (3-b)*8 +: 8];
            end
        end
        return res;
    endfunction

    assign engine_state  = state;
    assign chunk_bytes   = chunk_remaining;
    assign more_after    = (data_remaining != '0);
    assign chunk_address = write_address;

    // ==========================================================
    // Write FSM
    // ==========================================================
    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            state           <= WR_IDLE;
            cleanup_cnt     <= '0;
            data_remaining  <= '0;
            chunk_remaining <= '0;
            beat_dwords     <= '0;
            write_address   <= '0;
            tlp_keep_dw     <= '0;
            tlp_first       <= 1'b0;
            tlp_last        <= 1'b0;
            tlp_pending     <= 1'b0;
            tlp_valid       <= 1'b0;
            fifo_rd_en      <= 1'b0;
            fifo_flush      <= 1'b0;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (sel_has_data) begin
                        data_remaining <= sel_length;
                        write_address  <= sel_address;
                        state          <= WR_DATA_INIT;
                    end
                end
                WR_DATA_INIT: begin
                    if (sel_wr_done) begin   // Payload fully in FIFO
                        state <= WR_CALC_DATA;
                    end
                end
                WR_CALC_DATA: begin
                    if (data_remaining > MAX_PAYLOAD_BYTES) begin
                        chunk_remaining <= MAX_PAYLOAD_BYTES;
                        data_remaining  <= data_remaining - MAX_PAYLOAD_BYTES;
                    end else begin
                        chunk_remaining <= data_remaining;
                        data_remaining  <= '0;
                    end
                    state <= WR_PREPARE_HEADER;
                end
                WR_PREPARE_HEADER: begin
                    tlp_data      <= header;
                    tlp_keep_dw   <= 4'hF;
                    tlp_first     <= 1'b1;
                    tlp_last      <= 1'b0;
                    tlp_pending   <= 1'b1;
                    write_address <= write_address + chunk_remaining;
                    state         <= WR_TRANSMIT_HEADER;
                end
                WR_TRANSMIT_HEADER: begin
                    if (tlp_ready) begin
                        tlp_valid   <= 1'b1;
                        tlp_pending <= 1'b0;
                        state       <= WR_DEASSERT_HEADER;
                    end
                end
                WR_DEASSERT_HEADER: begin
                    tlp_valid <= 1'b0;
                    state     <= WR_GET_DATA_FIFO;
                end
                WR_GET_DATA_FIFO: begin
                    fifo_rd_en <= 1'b1;
                    if (chunk_remaining >= 32'd16) begin
                        beat_dwords     <= 3'd4;
                        chunk_remaining <= chunk_remaining - 32'd16;
                    end else begin
                        beat_dwords     <= 3'(chunk_remaining[3:2])
                                           + 3'(chunk_remaining[1:0] != 2'b00);
                        chunk_remaining <= '0;
                    end
                    state <= WR_WAIT_DATA_FIFO;
                end
                WR_WAIT_DATA_FIFO: begin
                    fifo_rd_en <= 1'b0;   // Single entry per beat
                    state      <= WR_PREPARE_DATA;
                end
                WR_PREPARE_DATA: begin
                    tlp_data    <= swap_dwords(fifo_dout);
                    tlp_keep_dw <= {beat_dwords >= 3'd4, beat_dwords >= 3'd3,
                                    beat_dwords >= 3'd2, beat_dwords >= 3'd1};
                    tlp_first   <= 1'b0;
                    tlp_last    <= (chunk_remaining == '0);
                    tlp_pending <= 1'b1;
                    state       <= WR_TRANSMIT_DATA;
                end
                WR_TRANSMIT_DATA: begin
                    if (tlp_ready) begin
                        tlp_valid   <= 1'b1;
                        tlp_pending <= 1'b0;
                        state       <= WR_DEASSERT_DATA;
                    end
                end
                WR_DEASSERT_DATA: begin
                    tlp_valid <= 1'b0;
                    if (chunk_remaining != '0) begin
                        state <= WR_GET_DATA_FIFO;
                    end else if (data_remaining != '0) begin
                        state <= WR_CALC_DATA;   // Next chunk
                    end else begin
                        state <= WR_COMPLETE;
                    end
                end
                WR_COMPLETE: begin
                    if (!sel_has_data) begin
                        fifo_flush  <= 1'b1;
                        cleanup_cnt <= '0;
                        state       <= WR_CLEANUP;
                    end
                end
                WR_CLEANUP: begin
                    tlp_keep_dw <= '0;
                    tlp_first   <= 1'b0;
                    tlp_last    <= 1'b0;
                    if (cleanup_cnt == 4'(CLEANUP_CYCLES - 1)) begin
                        fifo_flush <= 1'b0;
                        state      <= WR_IDLE;
                    end else begin
                        cleanup_cnt <= cleanup_cnt + 4'd1;
                    end
                end
                default: begin
                    state <= WR_IDLE;
                end
            endcase
        end
    end

    // ==========================================================
    // Stream checks
    // ==========================================================
    a_valid_pulse: assert property (@(posedge clk_pcie) disable iff (rst)
        tlp_valid |=> !tlp_valid);

endmodule

//--- src/host_mem_write.sv
`timescale 1ns/1ns

module host_mem_write #(
    parameter int N_REQ      = 3,
    parameter int FIFO_DEPTH = 128
) (
    input  logic                                         clk_pcie,
    input  logic                                         rst,
    input  logic [15:0]                                  pcie_id,
    input  host_mem_pkg::mem_addr_t [N_REQ-1:0]          req_address,
    input  host_mem_pkg::mem_len_t  [N_REQ-1:0]          req_length,
    input  logic                    [N_REQ-1:0]          req_has_data,
    input  host_mem_pkg::tlp_beat_t [N_REQ-1:0]          req_din,
    input  logic                    [N_REQ-1:0]          req_wr_en,
    input  logic                    [N_REQ-1:0]          req_wr_done,
    output host_mem_pkg::mem_write_state_t [N_REQ-1:0]   req_state,
    output host_mem_pkg::tlp_beat_t                      tlp_data,
    output host_mem_pkg::dw_keep_t                       tlp_keep_dw,
    output logic                                         tlp_first,
    output logic                                         tlp_last,
    output logic                                         tlp_pending,
    output logic                                         tlp_valid,
    input  logic                                         tlp_ready
);
    import host_mem_pkg::*;

    mem_write_state_t engine_state;
    mem_addr_t        sel_address;
    mem_len_t         sel_length;
    logic             sel_has_data;
    logic             sel_wr_done;
    tlp_beat_t        fifo_din;
    logic             fifo_wr_en;
    logic             fifo_rd_en;
    logic             fifo_flush;
    tlp_beat_t        fifo_dout;
    mem_len_t         chunk_bytes;
    logic             more_after;
    mem_addr_t        chunk_address;
    tlp_beat_t        header;

    // ==========================================================
    // Requester select and payload buffer
    // ==========================================================
    mem_write_arbiter #(
        .N_REQ (N_REQ)
    ) u_arbiter (
        .clk_pcie     (clk_pcie),
        .rst          (rst),
        .req_address  (req_address),
        .req_length   (req_length),
        .req_has_data (req_has_data),
        .req_din      (req_din),
        .req_wr_en    (req_wr_en),
        .req_wr_done  (req_wr_done),
        .req_state    (req_state),
        .engine_state (engine_state),
        .sel_address  (sel_address),
        .sel_length   (sel_length),
        .sel_has_data (sel_has_data),
        .sel_wr_done  (sel_wr_done),
        .fifo_din     (fifo_din),
        .fifo_wr_en   (fifo_wr_en)
    );

    payload_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk_pcie (clk_pcie),
        .rst      (rst),
        .flush    (fifo_flush),
        .wr_en    (fifo_wr_en),
        .din      (fifo_din),
        .rd_en    (fifo_rd_en),
        .dout     (fifo_dout),
        .empty    (),
        .full     ()
    );

    // ==========================================================
    // TLP generation
    // ==========================================================
    write_tlp_header u_header (
        .chunk_bytes (chunk_bytes),
        .more_after  (more_after),
        .address     (chunk_address),
        .pcie_id     (pcie_id),
        .header      (header)
    );

    write_tlp_engine u_engine (
        .clk_pcie      (clk_pcie),
        .rst           (rst),
        .sel_address   (sel_address),
        .sel_length    (sel_length),
        .sel_has_data  (sel_has_data),
        .sel_wr_done   (sel_wr_done),
        .fifo_dout     (fifo_dout),
        .tlp_ready     (tlp_ready),
        .header        (header),
        .chunk_bytes   (chunk_bytes),
        .more_after    (more_after),
        .chunk_address (chunk_address),
        .engine_state  (engine_state),
        .fifo_rd_en    (fifo_rd_en),
        .fifo_flush    (fifo_flush),
        .tlp_data      (tlp_data),
        .tlp_keep_dw   (tlp_keep_dw),
        .tlp_first     (tlp_first),
        .tlp_last      (tlp_last),
        .tlp_pending   (tlp_pending),
        .tlp_valid     (tlp_valid)
    );

endmodule

//--- tests/tb_host_mem_write.sv
`timescale 1ns/1ns

module tb_host_mem_write;
    import host_mem_pkg::*;

    localparam int N_REQ       = 3;
    localparam int NUM_REQS    = 40;
    localparam int MAX_LEN     = 600;
    localparam int MAX_GAP     = 20;
    localparam int HALF_PERIOD = 4;
    localparam int MAX_BEATS   = (MAX_LEN + 15) / 16 + (MAX_LEN + 127) / 128;
    // Entry writes, beats with ready stalls, cleanup and idle gap
    localparam int REQ_BOUND   = MAX_LEN / 16 + 2 + MAX_BEATS * 40 + CLEANUP_CYCLES
                                 + MAX_GAP + 32;
    localparam logic [15:0] PCIE_ID = 16'h01a4;

    logic                             clk_pcie;
    logic                             rst;
    logic [15:0]                      pcie_id;
    mem_addr_t        [N_REQ-1:0]     req_address;
    mem_len_t         [N_REQ-1:0]     req_length;
    logic             [N_REQ-1:0]     req_has_data;
    tlp_beat_t        [N_REQ-1:0]     req_din;
    logic             [N_REQ-1:0]     req_wr_en;
    logic             [N_REQ-1:0]     req_wr_done;
    mem_write_state_t [N_REQ-1:0]     req_state;
    tlp_beat_t                        tlp_data;
    dw_keep_t                         tlp_keep_dw;
    logic                             tlp_first;
    logic                             tlp_last;
    logic                             tlp_pending;
    logic                             tlp_valid;
    logic                             tlp_ready;

    // Requester side record, read by the model at selection
    tlp_beat_t        payload [N_REQ][64];
    mem_addr_t        cur_addr [N_REQ];
    mem_len_t         cur_len [N_REQ];

    tlp_beat_t        exp_data [$];
    dw_keep_t         exp_keep [$];
    logic [1:0]       exp_flags [$];   // {first, last}

    int               issued = 0;
    int               completed = 0;
    int               sel_id = -1;
    logic             done_seen = 1'b0;
    logic             running = 1'b0;
    logic             prev_valid = 1'b0;
    logic             prev_taken = 1'b0;
    logic [N_REQ-1:0] prev_has_data = '0;

    host_mem_write #(
        .N_REQ      (N_REQ),
        .FIFO_DEPTH (128)
    ) u_dut (
        .clk_pcie     (clk_pcie),
        .rst          (rst),
        .pcie_id      (pcie_id),
        .req_address  (req_address),
        .req_length   (req_length),
        .req_has_data (req_has_data),
        .req_din      (req_din),
        .req_wr_en    (req_wr_en),
        .req_wr_done  (req_wr_done),
        .req_state    (req_state),
        .tlp_data     (tlp_data),
        .tlp_keep_dw  (tlp_keep_dw),
        .tlp_first    (tlp_first),
        .tlp_last     (tlp_last),
        .tlp_pending  (tlp_pending),
        .tlp_valid    (tlp_valid),
        .tlp_ready    (tlp_ready)
    );

    initial clk_pcie = 1'b0;
    always #HALF_PERIOD clk_pcie = ~clk_pcie;

    // ==========================================================
    // Failure reporting and compare tasks
    // ==========================================================
    task automatic fail_run(string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_beat(string name, tlp_beat_t got, tlp_beat_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Error at %0t ns: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_keep(string name, dw_keep_t got, dw_keep_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Error at %0t ns: %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_flags(string name, logic [1:0] got, logic [1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("Error at %0t ns: %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_state(string name, mem_write_state_t got, mem_write_state_t exp);
        if (got !== exp) begin
            fail_run($sformatf("Error at %0t ns: %s got %s expected %s", $time, name,
                               got.name(), exp.name()));
        end
    endtask

    // ==========================================================
    // Reference model
    // ==========================================================
    function automatic byte_en_t tail_mask(int nbytes);
        int rem;
        rem = nbytes % 4;
        if (rem == 0) begin
            return 4'hF;
        end
        return byte_en_t'((1 << rem) - 1);
    endfunction

    function automatic tlp_beat_t expect_header(mem_addr_t addr, int chunk, bit more);
        tlp_beat_t hdr;
        byte_en_t  fbe;
        byte_en_t  lbe;
        int        dwords;
        dwords = (chunk + 3) / 4;
        fbe    = (chunk >= 4) ? 4'hF : tail_mask(chunk);
        if (more) begin
            lbe = 4'hF;
        end else if (chunk <= 4) begin
            lbe = 4'h0;
        end else begin
            lbe = tail_mask(chunk);
        end
        hdr         = '0;
        hdr[127:96] = addr[31:0];
        hdr[95:64]  = addr[63:32];
        hdr[63:56]  = PCIE_ID[7:0];   // Requester ID goes out byte-swapped
        hdr[55:48]  = PCIE_ID[15:8];
        hdr[39:36]  = lbe;
        hdr[35:32]  = fbe;
        hdr[31:24]  = FMT_TYPE_MWR64;
        hdr[9:0]    = dwords[9:0];
        return hdr;
    endfunction

    function automatic tlp_beat_t reverse_dwords(tlp_beat_t entry);
        tlp_beat_t   res;
        logic [31:0] w;
        for (int d = 0; d < 4; d++) begin
            w               = entry[d*32 +: 32];
            res[d*32 +: 32] = {w[7:0], w[15:8], w[23:16], w[31:24]};
        end
        return res;
    endfunction

    function automatic void queue_request(int id);
        mem_addr_t addr;
        int        remaining;
        int        chunk;
        int        beat_bytes;
        int        entry;
        addr      = cur_addr[id];
        remaining = int'(cur_len[id]);
        entry     = 0;
        while (remaining > 0) begin
            chunk     = (remaining > int'(MAX_PAYLOAD_BYTES)) ? int'(MAX_PAYLOAD_BYTES) : remaining;
            remaining = remaining - chunk;
            exp_data.push_back(expect_header(addr, chunk, remaining > 0));
            exp_keep.push_back(4'hF);
            exp_flags.push_back(2'b10);
            addr = addr + mem_addr_t'(chunk);
            for (int off = 0; off < chunk; off += 16) begin
                beat_bytes = (chunk - off > 16) ? 16 : chunk - off;
                exp_data.push_back(reverse_dwords(payload[id][entry]));
                exp_keep.push_back(dw_keep_t'((1 << ((beat_bytes + 3) / 4)) - 1));
                exp_flags.push_back({1'b0, off + 16 >= chunk});
                entry++;
            end
        end
    endfunction

    // ==========================================================
    // Monitors, sampled at the falling edge
    // ==========================================================
    task automatic check_stream();
        if (tlp_valid) begin
            if (prev_valid) begin
                fail_run("tlp_valid was high on two cycles in a row");
            end
            if (!prev_taken) begin
                fail_run("tlp_valid pulsed without tlp_pending and tlp_ready the cycle before");
            end
            if (tlp_pending) begin
                fail_run("tlp_pending was still high on the tlp_valid cycle");
            end
            if (exp_data.size() == 0) begin
                fail_run("tlp_valid pulsed while the model expected no beat");
            end
            check_beat("tlp_data", tlp_data, exp_data.pop_front());
            check_keep("tlp_keep_dw", tlp_keep_dw, exp_keep.pop_front());
            check_flags("tlp_first/tlp_last", {tlp_first, tlp_last}, exp_flags.pop_front());
        end else if (prev_taken) begin
            fail_run("A pending beat saw tlp_ready but no tlp_valid followed");
        end
        prev_valid = tlp_valid;
        prev_taken = tlp_pending && tlp_ready;
    endtask

    task automatic track_selection();
        int picked;
        int lowest;
        picked = -1;
        lowest = -1;
        if (sel_id < 0) begin
            for (int i = 0; i < N_REQ; i++) begin
                if (req_state[i] != WR_IDLE) begin
                    if (picked >= 0) begin
                        fail_run("Two requesters left WR_IDLE on the same cycle");
                    end
                    picked = i;
                end
                if (prev_has_data[i] && lowest < 0) begin
                    lowest = i;
                end
            end
            if (picked >= 0) begin
                check_state($sformatf("req_state[%0d]", picked), req_state[picked], WR_DATA_INIT);
                if (picked != lowest) begin
                    fail_run($sformatf("Error at %0t ns: selected requester got %0d expected %0d",
                                       $time, picked, lowest));
                end
                sel_id = picked;
                queue_request(picked);
            end
        end else begin
            for (int i = 0; i < N_REQ; i++) begin
                if (i != sel_id) begin
                    check_state($sformatf("req_state[%0d]", i), req_state[i], WR_IDLE);
                end
            end
            if (req_state[sel_id] == WR_COMPLETE && !done_seen) begin
                if (exp_data.size() != 0) begin
                    fail_run("A request reached WR_COMPLETE before all its beats were sent");
                end
                done_seen = 1'b1;
                completed++;
            end else if (req_state[sel_id] == WR_IDLE) begin
                if (!done_seen) begin
                    fail_run("A request went back to WR_IDLE without reaching WR_COMPLETE");
                end
                sel_id    = -1;
                done_seen = 1'b0;
            end
        end
    endtask

    always @(negedge clk_pcie) begin
        if (running) begin
            check_stream();
            track_selection();
        end
        prev_has_data = req_has_data;
    end

    // ==========================================================
    // Stimulus
    // ==========================================================
    task automatic step_cycle();
        @(posedge clk_pcie);
        #1;
    endtask

    task automatic drive_ready();
        forever begin
            step_cycle();
            tlp_ready = ($urandom_range(99, 0) >= 30);   // Low about 30%
        end
    endtask

    task automatic run_requester(int id);
        int entries;
        int surplus;
        while (issued < NUM_REQS) begin
            issued++;
            repeat ($urandom_range(MAX_GAP, 0) + 1) step_cycle();
            if ($urandom_range(3, 0) == 0) begin
                cur_len[id] = mem_len_t'($urandom_range(8, 1));   // Partial byte enables
            end else begin
                cur_len[id] = mem_len_t'($urandom_range(MAX_LEN, 1));
            end
            cur_addr[id] = {$urandom, $urandom};
            entries      = (int'(cur_len[id]) + 15) / 16;
            // Surplus entries are never read and must be gone after cleanup
            surplus      = ($urandom_range(1, 0) == 1) ? int'($urandom_range(3, 1)) : 0;
            for (int e = 0; e < entries + surplus; e++) begin
                payload[id][e] = {$urandom, $urandom, $urandom, $urandom};
            end
            req_address[id]  = cur_addr[id];
            req_length[id]   = cur_len[id];
            req_has_data[id] = 1'b1;
            // Payload goes in only once the engine holds this request
            do begin
                step_cycle();
            end while (req_state[id] != WR_DATA_INIT);
            for (int e = 0; e < entries + surplus; e++) begin
                req_din[id]   = payload[id][e];
                req_wr_en[id] = 1'b1;
                step_cycle();
            end
            req_wr_en[id]   = 1'b0;
            req_wr_done[id] = 1'b1;
            step_cycle();
            req_wr_done[id] = 1'b0;
            while (req_state[id] != WR_COMPLETE) begin
                step_cycle();
            end
            req_has_data[id] = 1'b0;
            while (req_state[id] != WR_IDLE) begin
                step_cycle();
            end
        end
    endtask

    initial begin
        void'($urandom(32'h883f_ff2f));
        rst          = 1'b1;
        pcie_id      = PCIE_ID;
        req_address  = '0;
        req_length   = '0;
        req_has_data = '0;
        req_din      = '0;
        req_wr_en    = '0;
        req_wr_done  = '0;
        tlp_ready    = 1'b0;
        repeat (4) @(posedge clk_pcie);
        for (int pass = 0; pass < 2; pass++) begin
            if (pass == 1) begin
                @(posedge clk_pcie);
                #1;
                rst = 1'b0;   // Five reset edges in total
            end
            @(negedge clk_pcie);
            check_flags("tlp_pending/tlp_valid", {tlp_pending, tlp_valid}, 2'b00);
            check_flags("tlp_first/tlp_last", {tlp_first, tlp_last}, 2'b00);
            check_keep("tlp_keep_dw", tlp_keep_dw, 4'h0);
            for (int i = 0; i < N_REQ; i++) begin
                check_state($sformatf("req_state[%0d]", i), req_state[i], WR_IDLE);
            end
        end
        running = 1'b1;
        fork
            drive_ready();
        join_none
        for (int i = 0; i < N_REQ; i++) begin
            fork
                automatic int id = i;
                run_requester(id);
            join_none
        end
        wait (completed == NUM_REQS);
        repeat (CLEANUP_CYCLES + 4) @(posedge clk_pcie);
        @(negedge clk_pcie);
        if (exp_data.size() == 0 && sel_id < 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            fail_run("Beats or a request were left over at the end of the run");
        end
    end

    // Watchdog
    initial begin
        #(NUM_REQS * REQ_BOUND * 2 * HALF_PERIOD);
        fail_run("Timeout: the requests did not all complete in the expected time");
    end

endmodule

//--- list.f
src/host_mem_pkg.sv
src/mem_write_arbiter.sv
src/payload_fifo.sv
src/write_tlp_header.sv
src/write_tlp_engine.sv
src/host_mem_write.sv
tests/tb_host_mem_write.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_host_mem_write
RTL_TOP    := host_mem_write
FILELIST   := list.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only -Wall -Wno-fatal --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal -j 0
PASS_MSG   := All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
